/* dv/accel_vectors.txt */
# P <instr hex> | M <pc_max dec> | R <read_addr hex> <read_data hex> | L <next_layer count dec>
# instr fields: op[31:30] group[29:23] index[22:16] data[15:0]
# lane 0 operands, readback, layer marker, launch of 5 iterations
P 41001234
P 41010056
P 41020000
P 81000000
P 81010000
P 40010000
P 40810005
P 81020000
P 81030000
# lanes 2 and 3 set up, then launched together for 7 iterations
P 42000300
P 42010200
P 42020000
P 4280ffff
P 42810002
P 42820000
P 40010000
P 408c0007
P 42000011
P 82020000
P 82030000
P 82820000
P 82830000
P 82000000
P 00000000
P 40010000
M 25
R 100 1234
R 101 0056
R 102 9358
R 103 001e
R 202 0000
R 203 002a
R 282 fff2
R 283 000d
R 200 0011
L 3

/* accel_top.f */
+incdir+source
source/isa_pkg.sv
source/regbus_pkg.sv
source/regbus_if.sv
source/program_memory.sv
source/program_driver.sv
source/lane_dispatch.sv
source/mac_lane.sv
source/response_merge.sv
source/accel_top.sv
dv/accel_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the accel_top testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module accel_tb -f accel_top.f \
    -o accel_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/accel_sim > sim.log 2>&1
cat sim.log
[ -s sim.log ] || { echo "simulation produced no output"; exit 1; }
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

/* dv/accel_tb.sv */
`default_nettype none

`include "accel_consts.svh"

module accel_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;
    import regbus_pkg::*;

    localparam int RUN_TIMEOUT   = 2000;
    localparam int DRAIN_TIMEOUT = 20;

    logic             clk;
    logic             rst;
    logic             load_en;
    logic [`PC_W-1:0] load_addr;
    instr_u           load_data;
    logic             run;
    logic [`PC_W-1:0] pc_max;
    logic             next_layer;
    logic             program_done;
    logic             read_valid;
    reg_addr_t        read_addr;
    reg_data_t        read_data;

    // contents of the vectors file
    instr_u    prog_q [$];
    reg_addr_t file_addr_q [$];
    reg_data_t file_data_q [$];
    int        file_pc_max;
    int        file_layers;

    // reads predicted from the program words
    reg_addr_t exp_addr_q [$];
    reg_data_t exp_data_q [$];
    int        model_layers;

    int layer_count;
    int done_count;
    int read_count;
    int since_done;

    accel_top dut (
        .clk          (clk),
        .rst          (rst),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .run          (run),
        .pc_max       (pc_max),
        .next_layer   (next_layer),
        .program_done (program_done),
        .read_valid   (read_valid),
        .read_addr    (read_addr),
        .read_data    (read_data)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_fail(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_fail($sformatf("FAILED at %0t: %s is %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            stop_with_fail($sformatf("FAILED at %0t: %s is %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_read(input reg_addr_t addr, input reg_data_t data);
        reg_addr_t ea;
        reg_data_t ed;
        if (exp_addr_q.size() == 0) begin
            stop_with_fail("read response arrived after all expected reads were seen");
        end
        ea = exp_addr_q.pop_front();
        ed = exp_data_q.pop_front();
        if (addr !== ea || data !== ed) begin
            stop_with_fail($sformatf("FAILED at %0t: read %h = %h, expected %h = %h",
                                     $time, addr, data, ea, ed));
        end
    endtask

    task automatic check_idle_outputs();
        check_flag("next_layer", next_layer, 1'b0);
        check_flag("program_done", program_done, 1'b0);
        check_flag("read_valid", read_valid, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // vectors and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic read_vectors();
        int          fd;
        int          code;
        string       tag;
        string       rest;
        logic [31:0] word;
        reg_addr_t   r_addr;
        reg_data_t   r_data;
        fd = $fopen("dv/accel_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_fail("could not open dv/accel_vectors.txt");
        end
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            case (tag)
                "#": code = $fgets(rest, fd);
                "P": begin
                    code = $fscanf(fd, "%h", word);
                    prog_q.push_back(word);
                end
                "M": code = $fscanf(fd, "%d", file_pc_max);
                "R": begin
                    code = $fscanf(fd, "%h %h", r_addr, r_data);
                    file_addr_q.push_back(r_addr);
                    file_data_q.push_back(r_data);
                end
                "L": code = $fscanf(fd, "%d", file_layers);
                default: stop_with_fail({"unknown record tag in vectors file: ", tag});
            endcase
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
    endtask

    // walks the program in order and predicts every lane read
    task automatic build_expected();
        instr_u      w;
        int          ln;
        reg_data_t   op_a [`NUM_LANES];
        reg_data_t   op_b [`NUM_LANES];
        logic [31:0] acc [`NUM_LANES];
        for (int k = 0; k < `NUM_LANES; k++) begin
            op_a[k] = '0;
            op_b[k] = '0;
            acc[k]  = '0;
        end
        for (int i = 0; i < prog_q.size(); i++) begin
            w  = prog_q[i];
            ln = int'(w.r.group) - int'(`GRP_LANE0);
            if (w.r.op == OP_WRITE && w.r.group == `GRP_LOCAL
                    && w.r.index == `LAYER_INDEX) begin
                model_layers++;
            end else if (w.l.op == OP_WRITE && w.l.group == `GRP_LAUNCH) begin
                for (int k = 0; k < `NUM_LANES; k++) begin
                    if (w.l.lane_mask[k]) begin
                        acc[k] = acc[k] + 32'(w.l.count) * 32'(op_a[k]) * 32'(op_b[k]);
                    end
                end
            end else if (ln >= 0 && ln < `NUM_LANES) begin
                if (w.r.op == OP_WRITE) begin
                    case (w.r.index[1:0])
                        `LANE_IDX_A:      op_a[ln] = w.r.data;
                        `LANE_IDX_B:      op_b[ln] = w.r.data;
                        `LANE_IDX_ACC_LO: acc[ln]  = '0;
                        default:          ;
                    endcase
                end else if (w.r.op == OP_READ) begin
                    exp_addr_q.push_back({w.r.group, w.r.index});
                    case (w.r.index[1:0])
                        `LANE_IDX_A:      exp_data_q.push_back(op_a[ln]);
                        `LANE_IDX_B:      exp_data_q.push_back(op_b[ln]);
                        `LANE_IDX_ACC_LO: exp_data_q.push_back(acc[ln][15:0]);
                        default:          exp_data_q.push_back(acc[ln][31:16]);
                    endcase
                end
            end
        end
    endtask

    task automatic compare_file_to_model();
        if (file_addr_q.size() != exp_addr_q.size()) begin
            stop_with_fail("vectors file R records do not match the reads in the program");
        end
        for (int i = 0; i < file_addr_q.size(); i++) begin
            if (file_addr_q[i] !== exp_addr_q[i] || file_data_q[i] !== exp_data_q[i]) begin
                stop_with_fail($sformatf("R record %0d disagrees with the program operands", i));
            end
        end
        if (file_layers != model_layers) begin
            stop_with_fail("L record disagrees with the layer markers in the program");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus and waits
    //////////////////////////////////////////////////////////////////////

    task automatic load_program();
        for (int i = 0; i < prog_q.size(); i++) begin
            @(posedge clk);
            #0.5;
            load_en   = 1'b1;
            load_addr = i[`PC_W-1:0];
            load_data = prog_q[i];
        end
        @(posedge clk);
        #0.5;
        load_en = 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        #0.5;
        pc_max = file_pc_max[`PC_W-1:0];
        run    = 1'b1;
        @(posedge clk);
        #0.5;
        run = 1'b0;
    endtask

    task automatic wait_program_done();
        int cycles;
        cycles = 0;
        while (done_count == 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                stop_with_fail("timeout while waiting for program_done");
            end
        end
    endtask

    // late read responses still show up in this window
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (since_done < 4) begin
            @(posedge clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                stop_with_fail("timeout while waiting for reads to drain after program_done");
            end
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (next_layer) begin
                layer_count++;
            end
            if (program_done) begin
                done_count++;
                since_done = 0;
            end else if (done_count > 0) begin
                since_done++;
            end
            if (read_valid) begin
                if (done_count > 0 && since_done > 2) begin
                    stop_with_fail("read response came more than 2 cycles after program_done");
                end
                read_count++;
                check_read(read_addr, read_data);
            end
        end
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk          = 1'b0;
        rst          = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        run          = 1'b0;
        pc_max       = '0;
        layer_count  = 0;
        done_count   = 0;
        read_count   = 0;
        since_done   = 0;
        model_layers = 0;
        file_pc_max  = 0;
        file_layers  = 0;

        read_vectors();
        build_expected();
        compare_file_to_model();

        // 8 rising edges in reset
        repeat (7) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        #0.5;
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end

        load_program();
        start_run();
        wait_program_done();
        wait_drain();

        check_count("read responses", read_count, file_addr_q.size());
        check_count("next_layer pulses", layer_count, file_layers);
        check_count("program_done pulses", done_count, 1);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* source/accel_top.sv */
`default_nettype none

`include "accel_consts.svh"

module accel_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_en,
    input  logic [`PC_W-1:0]      load_addr,
    input  isa_pkg::instr_u       load_data,
    input  logic                  run,
    input  logic [`PC_W-1:0]      pc_max,
    output logic                  next_layer,
    output logic                  program_done,
    output logic                  read_valid,
    output regbus_pkg::reg_addr_t read_addr,
    output regbus_pkg::reg_data_t read_data
);
    import isa_pkg::*;
    import regbus_pkg::*;

    logic                  re;
    logic [`PC_W-1:0]      pc;
    instr_u                instr;
    logic                  done_executing;
    logic [`NUM_LANES-1:0] lane_wr;
    logic [`NUM_LANES-1:0] lane_rd;
    logic [`NUM_LANES-1:0] lane_start;
    logic [1:0]            lane_index;
    reg_data_t             lane_data;
    logic [`NUM_LANES-1:0] lane_busy;
    logic [`NUM_LANES-1:0] lane_done;
    logic [`NUM_LANES-1:0] lane_rd_valid;
    reg_data_t             lane_rd_data [`NUM_LANES];
    logic [`NUM_LANES-1:0] launch_mask;
    reg_addr_t             rd_addr;

    regbus_if bus ();

    program_memory u_program_memory (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .re        (re),
        .rd_addr   (pc),
        .data_out  (instr)
    );

    program_driver u_program_driver (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .pc_max         (pc_max),
        .re             (re),
        .pc             (pc),
        .instr          (instr),
        .bus            (bus.master),
        .done_executing (done_executing),
        .next_layer     (next_layer),
        .program_done   (program_done)
    );

    lane_dispatch u_lane_dispatch (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus.slave),
        .lane_wr     (lane_wr),
        .lane_rd     (lane_rd),
        .lane_start  (lane_start),
        .lane_index  (lane_index),
        .lane_data   (lane_data),
        .lane_busy   (lane_busy),
        .launch_mask (launch_mask),
        .rd_addr     (rd_addr)
    );

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        mac_lane u_mac_lane (
            .clk      (clk),
            .rst      (rst),
            .wr       (lane_wr[i]),
            .rd       (lane_rd[i]),
            .start    (lane_start[i]),
            .index    (lane_index),
            .data     (lane_data),
            .busy     (lane_busy[i]),
            .done     (lane_done[i]),
            .rd_valid (lane_rd_valid[i]),
            .rd_data  (lane_rd_data[i])
        );
    end

    response_merge u_response_merge (
        .clk            (clk),
        .rst            (rst),
        .rd_valid       (lane_rd_valid),
        .rd_data        (lane_rd_data),
        .rd_addr        (rd_addr),
        .lane_done      (lane_done),
        .launch_mask    (launch_mask),
        .done_executing (done_executing),
        .read_valid     (read_valid),
        .read_addr      (read_addr),
        .read_data      (read_data)
    );

endmodule

`default_nettype wire

/* source/response_merge.sv */
`default_nettype none

`include "accel_consts.svh"

module response_merge (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`NUM_LANES-1:0] rd_valid,
    input  regbus_pkg::reg_data_t rd_data [`NUM_LANES],
    input  regbus_pkg::reg_addr_t rd_addr,
    input  logic [`NUM_LANES-1:0] lane_done,
    input  logic [`NUM_LANES-1:0] launch_mask,
    output logic                  done_executing,
    output logic                  read_valid,
    output regbus_pkg::reg_addr_t read_addr,
    output regbus_pkg::reg_data_t read_data
);
    import regbus_pkg::*;

    reg_data_t             sel_data;
    logic [`NUM_LANES-1:0] armed;
    logic [`NUM_LANES-1:0] armed_next;

    always_comb begin
        sel_data = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (rd_valid[i]) begin
                sel_data = rd_data[i];
            end
        end
    end

    assign armed_next = (armed | launch_mask) & ~lane_done;

    always_ff @(posedge clk) begin
        if (|rd_valid) begin
            read_addr <= rd_addr;
            read_data <= sel_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_valid     <= 1'b0;
            armed          <= '0;
            done_executing <= 1'b0;
        end else begin
            read_valid     <= |rd_valid;
            armed          <= armed_next;
            // last launched lane has finished
            done_executing <= armed != '0 && armed_next == '0;
        end
    end

    // reads retire one per cycle, so only one lane answers
    a_single_response: assert property (
        @(posedge clk) disable iff (rst) $onehot0(rd_valid)
    );

endmodule

`default_nettype wire

/* source/mac_lane.sv */
`default_nettype none

`include "accel_consts.svh"

module mac_lane (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr,
    input  logic                  rd,
    input  logic                  start,
    input  logic [1:0]            index,
    input  regbus_pkg::reg_data_t data,
    output logic                  busy,
    output logic                  done,
    output logic                  rd_valid,
    output regbus_pkg::reg_data_t rd_data
);
    import regbus_pkg::*;

    reg_data_t   op_a;
    reg_data_t   op_b;
    reg_data_t   iter;
    logic [31:0] acc;

    //////////////////////////////////////////////////////////////////////
    // iteration control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            rd_valid <= 1'b0;
            iter     <= '0;
        end else begin
            done     <= 1'b0;
            rd_valid <= rd;
            if (start) begin
                // a zero count finishes at once
                if (data == '0) begin
                    done <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    iter <= data;
                end
            end else if (busy) begin
                iter <= iter - 1'b1;
                if (iter == 16'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr) begin
            case (index)
                `LANE_IDX_A:      op_a <= data;
                `LANE_IDX_B:      op_b <= data;
                `LANE_IDX_ACC_LO: acc  <= '0;
                default:          ;
            endcase
        end
        if (busy) begin
            acc <= acc + 32'(op_a) * 32'(op_b);
        end
        if (rd) begin
            case (index)
                `LANE_IDX_A:      rd_data <= op_a;
                `LANE_IDX_B:      rd_data <= op_b;
                `LANE_IDX_ACC_LO: rd_data <= acc[15:0];
                default:          rd_data <= acc[31:16];
            endcase
        end
    end

    // dispatcher holds writes back until the lane is idle
    a_no_write_while_busy: assert property (
        @(posedge clk) disable iff (rst) !(wr && busy)
    );

endmodule

`default_nettype wire

/* source/lane_dispatch.sv */
`default_nettype none

`include "accel_consts.svh"

module lane_dispatch (
    input  logic                  clk,
    input  logic                  rst,
    regbus_if.slave               bus,
    output logic [`NUM_LANES-1:0] lane_wr,
    output logic [`NUM_LANES-1:0] lane_rd,
    output logic [`NUM_LANES-1:0] lane_start,
    output logic [1:0]            lane_index,
    output regbus_pkg::reg_data_t lane_data,
    input  logic [`NUM_LANES-1:0] lane_busy,
    output logic [`NUM_LANES-1:0] launch_mask,
    output regbus_pkg::reg_addr_t rd_addr
);
    import regbus_pkg::*;

    localparam int DEPTH = `CMD_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    reg_cmd_t              queue [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;
    reg_cmd_t              head;
    logic [`GRP_W-1:0]     grp;
    logic [`NUM_LANES-1:0] target;
    logic                  retire;

    assign head = queue[rd_ptr];
    assign grp  = head.addr[`ADDR_W-1:`IDX_W];

    // one-hot lane for register access, lane mask for a launch
    always_comb begin
        target = '0;
        if (head.kind == CMD_LAUNCH) begin
            target = head.addr[`NUM_LANES-1:0];
        end else begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                if (grp == 7'(`GRP_LANE0 + i)) begin
                    target[i] = 1'b1;
                end
            end
        end
    end

    // head waits until every lane it touches is idle
    assign retire = count != '0 && (target & lane_busy) == '0;

    assign lane_wr     = (retire && head.kind == CMD_WRITE) ? target : '0;
    assign lane_rd     = (retire && head.kind == CMD_READ) ? target : '0;
    assign lane_start  = (retire && head.kind == CMD_LAUNCH) ? target : '0;
    assign launch_mask = lane_start;
    assign lane_index  = head.addr[1:0];
    assign lane_data   = head.data;

    assign bus.credit_return = retire;

    always_ff @(posedge clk) begin
        if (bus.cmd_valid) begin
            queue[wr_ptr] <= bus.cmd;
        end
        // tag lines up with the lane's rd_valid
        if (retire && head.kind == CMD_READ) begin
            rd_addr <= head.addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (bus.cmd_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({bus.cmd_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the driver's credits keep the queue from overflowing
    a_queue_no_overflow: assert property (
        @(posedge clk) disable iff (rst) bus.cmd_valid |-> count < DEPTH
    );

endmodule

`default_nettype wire

/* source/program_driver.sv */
`default_nettype none

`include "accel_consts.svh"

module program_driver (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic [`PC_W-1:0] pc_max,
    output logic             re,
    output logic [`PC_W-1:0] pc,
    input  isa_pkg::instr_u  instr,
    regbus_if.master         bus,
    input  logic             done_executing,
    output logic             next_layer,
    output logic             program_done
);
    import isa_pkg::*;
    import regbus_pkg::*;

    localparam int CRED_W = $clog2(`CMD_CREDITS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_ISSUE,
        S_WAIT
    } drv_state_e;

    drv_state_e        state;
    logic              active;
    logic [CRED_W-1:0] credits;
    logic              is_write;
    logic              is_read;
    logic              is_layer;
    logic              is_launch;
    logic              send;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign is_write  = instr.r.op == OP_WRITE;
    assign is_read   = instr.r.op == OP_READ;
    assign is_layer  = is_write && instr.r.group == `GRP_LOCAL
                       && instr.r.index == `LAYER_INDEX;
    assign is_launch = instr.l.op == OP_WRITE && instr.l.group == `GRP_LAUNCH;
    // group 0 stays local, everything else goes on the bus
    assign send      = (is_write || is_read) && instr.r.group != `GRP_LOCAL;

    always_comb begin
        bus.cmd.kind = is_launch ? CMD_LAUNCH : (is_read ? CMD_READ : CMD_WRITE);
        // launch mask and count sit in the index and data fields
        bus.cmd.addr = {instr.r.group, instr.r.index};
        bus.cmd.data = instr.r.data;
    end

    assign bus.cmd_valid = state == S_ISSUE && send && credits != '0;
    assign re            = state == S_IDLE && active && pc < pc_max;

    //////////////////////////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= S_IDLE;
            active       <= 1'b0;
            pc           <= '0;
            next_layer   <= 1'b0;
            program_done <= 1'b0;
        end else begin
            next_layer   <= 1'b0;
            program_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    // run is taken as a start pulse
                    if (!active) begin
                        if (run) begin
                            active <= 1'b1;
                            pc     <= '0;
                        end
                    end else if (pc < pc_max) begin
                        state <= S_FETCH;
                    end else begin
                        active       <= 1'b0;
                        program_done <= 1'b1;
                    end
                end
                S_FETCH: begin
                    pc    <= pc + 1'b1;
                    state <= S_ISSUE;
                end
                S_ISSUE: begin
                    if (is_layer) begin
                        next_layer <= 1'b1;
                    end
                    if (!send) begin
                        state <= S_IDLE;
                    end else if (credits != '0) begin
                        state <= is_launch ? S_WAIT : S_IDLE;
                    end
                end
                S_WAIT: begin
                    if (done_executing) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CRED_W'(`CMD_CREDITS);
        end else begin
            case ({bus.cmd_valid, bus.credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // dispatcher never returns more credits than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst) credits <= `CMD_CREDITS
    );

endmodule

`default_nettype wire

/* source/program_memory.sv */
`default_nettype none

`include "accel_consts.svh"

module program_memory (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_en,
    input  logic [`PC_W-1:0] load_addr,
    input  isa_pkg::instr_u load_data,
    input  logic            re,
    input  logic [`PC_W-1:0] rd_addr,
    output isa_pkg::instr_u data_out
);
    import isa_pkg::*;

    instr_u mem [`PROG_DEPTH];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        // output holds until the next fetch
        if (re) begin
            data_out <= mem[rd_addr];
        end
    end

    // loading is finished before the driver starts fetching
    a_no_load_during_fetch: assert property (
        @(posedge clk) disable iff (rst) !(load_en && re)
    );

endmodule

`default_nettype wire

/* source/regbus_if.sv */
`default_nettype none

// command stream from the driver, one credit per command in flight
interface regbus_if;
    import regbus_pkg::*;

    logic     cmd_valid;
    reg_cmd_t cmd;
    logic     credit_return;

    modport master (
        output cmd_valid,
        output cmd,
        input  credit_return
    );

    modport slave (
        input  cmd_valid,
        input  cmd,
        output credit_return
    );

endinterface

`default_nettype wire

/* source/regbus_pkg.sv */
`default_nettype none

`include "accel_consts.svh"

package regbus_pkg;

    typedef logic [`ADDR_W-1:0] reg_addr_t;
    typedef logic [`DATA_W-1:0] reg_data_t;

    typedef enum logic [1:0] {
        CMD_WRITE  = 2'd0,
        CMD_READ   = 2'd1,
        CMD_LAUNCH = 2'd2
    } cmd_kind_e;

    typedef struct packed {
        cmd_kind_e kind;
        reg_addr_t addr;
        reg_data_t data;
    } reg_cmd_t;

endpackage

`default_nettype wire

/* source/isa_pkg.sv */
`default_nettype none

`include "accel_consts.svh"

package isa_pkg;

    typedef enum logic [1:0] {
        OP_NOP   = 2'b00,
        OP_WRITE = 2'b01,
        OP_READ  = 2'b10,
        OP_HALT  = 2'b11
    } opcode_e;

    // register form: group and index address one register
    typedef struct packed {
        opcode_e               op;
        logic [`GRP_W-1:0]     group;
        logic [`IDX_W-1:0]     index;
        logic [`DATA_W-1:0]    data;
    } reg_instr_t;

    // launch form: index field carries the lane mask, data the iteration count
    typedef struct packed {
        opcode_e               op;
        logic [`GRP_W-1:0]     group;
        logic [`IDX_W-1:0]     lane_mask;
        logic [`DATA_W-1:0]    count;
    } launch_instr_t;

    typedef union packed {
        reg_instr_t    r;
        launch_instr_t l;
    } instr_u;

endpackage

`default_nettype wire

/* source/accel_consts.svh */
`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

// array size and program store
`define NUM_LANES    4
`define PROG_DEPTH   256
`define PC_W         8
`define CMD_CREDITS  2

// register bus fields
`define GRP_W        7
`define IDX_W        7
`define ADDR_W       14
`define DATA_W       16

// group address map
`define GRP_LOCAL    7'd0
`define GRP_LAUNCH   7'd1
`define GRP_LANE0    7'd2
`define LAYER_INDEX  7'd1

// lane register indexes
`define LANE_IDX_A      2'd0
`define LANE_IDX_B      2'd1
`define LANE_IDX_ACC_LO 2'd2
`define LANE_IDX_ACC_HI 2'd3

`endif
